//--- arb_share.f
src/arb_share_pkg.sv
src/axil_if.sv
src/req_capture.sv
src/rr_arbiter.sv
src/axil_issue.sv
src/reg_bank.sv
src/arb_share_top.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_arb_share.sv

//--- bench/tb_arb_share.sv
`default_nettype none
`timescale 1ns/1ps

module tb_arb_share
  import arb_share_pkg::*;
();

  localparam int num_req   = num_req_c;
  localparam int num_rows  = 16;
  localparam int row_limit = 300;

  logic                  clk;
  logic                  rst_n;
  logic [num_req-1:0]    req_valid;
  logic [num_req-1:0]    req_ready;
  logic [num_req-1:0]    req_write;
  addr_t [num_req-1:0]   req_addr;
  data_t [num_req-1:0]   req_wdata;
  logic [num_req-1:0]    rsp_valid;
  data_t                 rsp_rdata;
  logic                  rsp_error;

  // stimulus table
  // a requester with zero repeats stays idle for the row
  string row_name  [num_rows];
  int    row_reps  [num_rows][num_req];
  int    row_delay [num_rows][num_req];
  logic  row_write [num_rows][num_req];
  addr_t row_addr  [num_rows][num_req];
  data_t row_data  [num_rows][num_req];
  int    seed;
  bit    timed_out;

  tb_clkgen #(.period_ns(8)) u_clk (.clk(clk));

  arb_share_top #(.num_requesters(num_req)) uut (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
    .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_error(rsp_error)
  );

  tb_checker #(.num_requesters(num_req)) u_chk (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
    .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_error(rsp_error)
  );

  task automatic set_cmd(input int r, input int i, input logic wr, input addr_t a,
                         input data_t d, input int reps, input int dly);
    row_write[r][i] = wr;
    row_addr[r][i]  = a;
    row_data[r][i]  = d;
    row_reps[r][i]  = reps;
    row_delay[r][i] = dly;
  endtask

  // ------------------------------------------------------------------
  // table contents
  // ------------------------------------------------------------------
  task automatic build_table();
    logic [31:0] rnd;
    for (int r = 0; r < num_rows; r++) begin
      for (int i = 0; i < num_req; i++) begin
        set_cmd(r, i, 1'b0, '0, '0, 0, 0);
      end
    end
    // all four on one edge
    // priority out of reset gives the order 0 to 3
    row_name[0] = "four_writes";
    row_name[1] = "four_reads";
    for (int i = 0; i < num_req; i++) begin
      set_cmd(0, i, 1'b1, addr_t'(8'h20 + 4 * i), data_t'(32'h1111_1111 * (i + 1)), 1, 0);
      set_cmd(1, i, 1'b0, addr_t'(8'h20 + 4 * i), '0, 1, 0);
    end
    row_name[2] = "single_write";
    set_cmd(2, 2, 1'b1, 8'h10, 32'hcafe_f00d, 1, 0);
    row_name[3] = "single_read";
    set_cmd(3, 2, 1'b0, 8'h10, '0, 1, 0);
    // 1 and 3 reissue right away while 0 joins a few cycles in
    row_name[4] = "contention";
    set_cmd(4, 1, 1'b1, 8'h14, 32'h5a5a_0000, 4, 0);
    set_cmd(4, 3, 1'b0, 8'h14, '0, 4, 0);
    set_cmd(4, 0, 1'b1, 8'h18, 32'h0f0f_0000, 2, 6);
    row_name[5] = "out_of_range";
    set_cmd(5, 2, 1'b1, 8'h44, 32'hdead_beef, 1, 0);
    set_cmd(5, 1, 1'b0, 8'hfc, '0, 1, 0);
    set_cmd(5, 0, 1'b1, 8'h80, 32'h1234_5678, 1, 0);
    // read back the whole bank with four words per row
    for (int k = 0; k < 4; k++) begin
      row_name[6 + k] = $sformatf("sweep_%0d", k);
      for (int i = 0; i < num_req; i++) begin
        set_cmd(6 + k, i, 1'b0, addr_t'(16 * k + 4 * i), '0, 1, 0);
      end
    end
    for (int r = 10; r < num_rows; r++) begin
      row_name[r] = $sformatf("random_%0d", r - 10);
      rnd = $random(seed);
      for (int i = 0; i < num_req; i++) begin
        // at least one requester per row
        if (rnd[i] || i == r % num_req) begin
          set_cmd(r, i, rnd[4 + i], addr_t'(({$random(seed)} % 16) * 4),
                  data_t'($random(seed)), 1, int'(rnd[9 + 2 * i +: 2]));
        end
      end
    end
  endtask

  // ------------------------------------------------------------------
  // apply one row until every command has its response
  // ------------------------------------------------------------------
  task automatic run_row(input int r);
    int remaining [num_req];
    int delay     [num_req];
    bit waiting   [num_req];
    bit drop      [num_req];
    int cycles;
    bit done;
    bit hs_left;
    for (int i = 0; i < num_req; i++) begin
      remaining[i] = row_reps[r][i];
      delay[i]     = row_delay[r][i];
      waiting[i]   = 1'b0;
      drop[i]      = 1'b0;
    end
    cycles = 0;
    done   = 1'b0;
    while (!done && !timed_out) begin
      @(negedge clk);
      for (int i = 0; i < num_req; i++) begin
        if (drop[i]) begin
          req_valid[i] = 1'b0;
          drop[i]      = 1'b0;
        end
        if (delay[i] > 0) begin
          delay[i]--;
        end else if (remaining[i] > 0 && !waiting[i] && !req_valid[i]) begin
          req_valid[i] = 1'b1;
          req_write[i] = row_write[r][i];
          req_addr[i]  = row_addr[r][i];
          // repeats carry their own data so back-to-back writes differ
          req_wdata[i] = row_data[r][i] ^ data_t'(remaining[i] - 1);
        end
      end
      @(posedge clk);
      done    = 1'b1;
      hs_left = 1'b0;
      for (int i = 0; i < num_req; i++) begin
        if (req_valid[i] && req_ready[i]) begin
          waiting[i] = 1'b1;
          drop[i]    = 1'b1;
          remaining[i]--;
        end
        if (rsp_valid[i]) waiting[i] = 1'b0;
        if (remaining[i] > 0) hs_left = 1'b1;
        if (remaining[i] > 0 || waiting[i]) done = 1'b0;
      end
      cycles++;
      if (!done && cycles >= row_limit) begin
        timed_out = 1'b1;
        $display("error: test %s timed out after %0d cycles waiting for %s",
                 row_name[r], cycles, hs_left ? "handshakes" : "responses");
      end
    end
  endtask

  initial begin
    int errors_before;
    rst_n     = 1'b0;
    req_valid = '0;
    req_write = '0;
    req_addr  = '0;
    req_wdata = '0;
    timed_out = 1'b0;
    seed      = 32'ha8c025dd;
    build_table();
    // reset low for 5 rising edges
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < num_rows && !timed_out; r++) begin
      errors_before = u_chk.fail_count;
      run_row(r);
      if (u_chk.fail_count == errors_before && !timed_out) begin
        $display("test %s: ok", row_name[r]);
      end else begin
        $display("test %s: failed, %0d errors", row_name[r], u_chk.fail_count - errors_before);
      end
    end
    $display("checks passed %0d, failed %0d", u_chk.pass_count, u_chk.fail_count);
    if (u_chk.fail_count == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
`default_nettype none
`timescale 1ns/1ps

module tb_checker
  import arb_share_pkg::*;
#(
  parameter int num_requesters = num_req_c
) (
  input logic                       clk,
  input logic                       rst_n,
  input logic [num_requesters-1:0]  req_valid,
  input logic [num_requesters-1:0]  req_ready,
  input logic [num_requesters-1:0]  req_write,
  input addr_t [num_requesters-1:0] req_addr,
  input data_t [num_requesters-1:0] req_wdata,
  input logic [num_requesters-1:0]  rsp_valid,
  input data_t                      rsp_rdata,
  input logic                       rsp_error
);

  int pass_count = 0;
  int fail_count = 0;

  // register contents as the requesters should see them
  data_t model_regs [num_regs_c];

  // one accepted command per requester waiting for its turn
  logic  pend_v [num_requesters];
  logic  pend_w [num_requesters];
  addr_t pend_a [num_requesters];
  data_t pend_d [num_requesters];

  // command currently on the bus
  logic  busy;
  int    owner;
  logic  cur_w;
  addr_t cur_a;
  data_t cur_d;
  // index with the lowest priority
  // the one after it goes first
  int    last_idx;

  // ready comes up one cycle after reset ends
  logic                      first_edge;
  logic [num_requesters-1:0] exp_ready;

  task automatic record_check(input bit ok, input string msg);
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("mismatch at %0t: %s", $time, msg);
    end
  endtask

  // ------------------------------------------------------------------
  // round-robin model
  // ------------------------------------------------------------------
  // search upward from the last grant and wrap
  // the first pending slot wins
  task automatic take_next();
    int idx;
    for (int k = 1; k <= num_requesters; k++) begin
      idx = (last_idx + k) % num_requesters;
      if (pend_v[idx] && !busy) begin
        busy        = 1'b1;
        owner       = idx;
        cur_w       = pend_w[idx];
        cur_a       = pend_a[idx];
        cur_d       = pend_d[idx];
        pend_v[idx] = 1'b0;
        last_idx    = idx;
      end
    end
  endtask

  // compare one response against the register model
  task automatic check_response();
    logic [num_requesters-1:0] exp_vld;
    bit                        in_range;
    int                        word;
    data_t                     exp_data;
    exp_vld        = '0;
    exp_vld[owner] = 1'b1;
    // bank covers byte addresses below 0x40 with one word per 4 bytes
    in_range = (cur_a < 8'h40);
    word     = int'(cur_a) / 4;
    exp_data = in_range ? model_regs[word] : '0;
    record_check(rsp_valid == exp_vld, $sformatf("rsp_valid %b, expected %b (owner %0d)",
      rsp_valid, exp_vld, owner));
    record_check(rsp_error == !in_range, $sformatf("rsp_error %b for addr 0x%h",
      rsp_error, cur_a));
    if (!cur_w) begin
      record_check(rsp_rdata == exp_data, $sformatf("read 0x%h gave 0x%h, expected 0x%h",
        cur_a, rsp_rdata, exp_data));
    end else if (in_range) begin
      model_regs[word] = cur_d;
    end
  endtask

  // ------------------------------------------------------------------
  // sampling on the rising edge while inputs move on the falling one
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      busy       = 1'b0;
      first_edge = 1'b1;
      last_idx   = num_requesters - 1;
      for (int i = 0; i < num_requesters; i++) begin
        pend_v[i] = 1'b0;
      end
      for (int r = 0; r < num_regs_c; r++) begin
        model_regs[r] = '0;
      end
    end else begin
      // a slot is full from its handshake until the take
      for (int i = 0; i < num_requesters; i++) begin
        exp_ready[i] = !pend_v[i] && !first_edge;
      end
      record_check(req_ready == exp_ready, $sformatf("req_ready %b, expected %b",
        req_ready, exp_ready));
      first_edge = 1'b0;
      if (rsp_valid != '0 && busy) begin
        check_response();
        busy = 1'b0;
      end else if (rsp_valid != '0) begin
        fail_count++;
        $display("error at %0t: response pulse with no command on the bus", $time);
      end else if (!busy) begin
        take_next();
      end
      // commands accepted here are only eligible from the next edge
      for (int i = 0; i < num_requesters; i++) begin
        if (req_valid[i] && req_ready[i]) begin
          pend_v[i] = 1'b1;
          pend_w[i] = req_write[i];
          pend_a[i] = req_addr[i];
          pend_d[i] = req_wdata[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int period_ns = 8
) (
  output logic clk
);

  // free running, starts low
  initial clk = 1'b0;

  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_arb_share \
  -f arb_share.f -o tb_arb_share_sim > build.log 2>&1 &&
  ./obj_dir/tb_arb_share_sim > sim.log 2>&1 ||
  { echo "build or simulation did not complete"; cat build.log sim.log; exit 1; }
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

//--- src/arb_share_pkg.sv
`default_nettype none

package arb_share_pkg;

  // requester count used as the top level default
  localparam int num_req_c = 4;

  // size of the register bank, one word per entry
  localparam int num_regs_c = 16;

  // byte address, word index in bits 5 to 2
  // anything at 0x40 or above is outside the bank
  typedef logic [7:0] addr_t;

  // register and bus data width
  typedef logic [31:0] data_t;

  // axi4-lite response codes, only the two that the bank produces
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  // issuer FSM
  typedef enum logic [1:0] {st_idle, st_write, st_read, st_resp} issue_state_t;

endpackage

`default_nettype wire

//--- src/arb_share_top.sv
`default_nettype none
`timescale 1ns/1ps

module arb_share_top
  import arb_share_pkg::*;
#(
  parameter int num_requesters = num_req_c
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [num_requesters-1:0]  req_valid,
  output logic [num_requesters-1:0]  req_ready,
  input  logic [num_requesters-1:0]  req_write,
  input  addr_t [num_requesters-1:0] req_addr,
  input  data_t [num_requesters-1:0] req_wdata,
  output logic [num_requesters-1:0]  rsp_valid,
  output data_t                      rsp_rdata,
  output logic                       rsp_error
);

  // ------------------------------------------------------------------
  // stage wiring
  // ------------------------------------------------------------------
  logic [num_requesters-1:0]  pending;
  logic [num_requesters-1:0]  grant;
  logic [num_requesters-1:0]  grant_take;
  logic                       take;
  logic [num_requesters-1:0]  cmd_write;
  addr_t [num_requesters-1:0] cmd_addr;
  data_t [num_requesters-1:0] cmd_wdata;

  axil_if bus_if ();

  // input side, one slot per requester
  req_capture #(.num_requesters(num_requesters)) u_capture (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
    .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
    .grant_take(grant_take), .pending(pending), .cmd_write(cmd_write),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata)
  );

  // priority rotates only when the issuer takes a grant
  rr_arbiter #(.num_requesters(num_requesters)) u_arbiter (
    .clk(clk), .rst_n(rst_n), .enable_priority_update(take),
    .request(pending), .grant(grant)
  );

  axil_issue #(.num_requesters(num_requesters)) u_issue (
    .clk(clk), .rst_n(rst_n), .grant(grant), .cmd_write(cmd_write),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .take(take),
    .grant_take(grant_take), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
    .rsp_error(rsp_error), .bus(bus_if.manager)
  );

  reg_bank u_bank (
    .clk(clk), .rst_n(rst_n), .bus(bus_if.subordinate)
  );

endmodule

`default_nettype wire

//--- src/axil_if.sv
`default_nettype none
`timescale 1ns/1ps

interface axil_if
  import arb_share_pkg::*;
();

  // write address and write data channels
  logic  aw_valid;
  logic  aw_ready;
  addr_t aw_addr;
  logic  w_valid;
  logic  w_ready;
  data_t w_data;

  // write response channel
  logic  b_valid;
  logic  b_ready;
  resp_t b_resp;

  // read address and read data channels
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  data_t r_data;
  resp_t r_resp;

  modport manager (
    output aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
    input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

  modport subordinate (
    input  aw_valid, aw_addr, w_valid, w_data, b_ready, ar_valid, ar_addr, r_ready,
    output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
  );

endinterface

`default_nettype wire

//--- src/axil_issue.sv
`default_nettype none
`timescale 1ns/1ps

module axil_issue
  import arb_share_pkg::*;
#(
  parameter int num_requesters = num_req_c
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [num_requesters-1:0]  grant,
  input  logic [num_requesters-1:0]  cmd_write,
  input  addr_t [num_requesters-1:0] cmd_addr,
  input  data_t [num_requesters-1:0] cmd_wdata,
  output logic                       take,
  output logic [num_requesters-1:0]  grant_take,
  output logic [num_requesters-1:0]  rsp_valid,
  output data_t                      rsp_rdata,
  output logic                       rsp_error,
  axil_if.manager                    bus
);

  issue_state_t              state_q;
  logic                      aw_valid_q;
  logic                      w_valid_q;
  logic                      ar_valid_q;
  logic [num_requesters-1:0] owner_q;
  addr_t                     addr_q;
  data_t                     wdata_q;
  logic                      sel_write;
  addr_t                     sel_addr;
  data_t                     sel_wdata;
  logic                      b_done;
  logic                      r_done;

  // ------------------------------------------------------------------
  // pick the granted slot
  // ------------------------------------------------------------------
  always_comb begin
    sel_write = 1'b0;
    sel_addr  = '0;
    sel_wdata = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (grant[i]) begin
        sel_write = cmd_write[i];
        sel_addr  = cmd_addr[i];
        sel_wdata = cmd_wdata[i];
      end
    end
  end

  // take only from idle, one transaction in flight
  assign take       = (state_q == st_idle) && (|grant);
  assign grant_take = grant & {num_requesters{take}};
  assign b_done     = bus.b_valid && bus.b_ready;
  assign r_done     = bus.r_valid && bus.r_ready;

  // ------------------------------------------------------------------
  // FSM and channel valids
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= st_idle;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
    end else begin
      // each valid drops on its own ready
      if (bus.aw_ready) aw_valid_q <= 1'b0;
      if (bus.w_ready) w_valid_q <= 1'b0;
      if (bus.ar_ready) ar_valid_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (take && sel_write) begin
            state_q    <= st_write;
            aw_valid_q <= 1'b1;
            w_valid_q  <= 1'b1;
          end else if (take) begin
            state_q    <= st_read;
            ar_valid_q <= 1'b1;
          end
        end
        st_write: if (b_done) state_q <= st_resp;
        st_read:  if (r_done) state_q <= st_resp;
        default:  state_q <= st_idle;
      endcase
    end
  end

  // command and response payload
  always_ff @(posedge clk) begin
    if (take) begin
      owner_q <= grant;
      addr_q  <= sel_addr;
      wdata_q <= sel_wdata;
    end
    if (b_done && state_q == st_write) begin
      rsp_rdata <= '0;
      rsp_error <= (bus.b_resp == resp_slverr);
    end
    if (r_done && state_q == st_read) begin
      rsp_rdata <= bus.r_data;
      rsp_error <= (bus.r_resp == resp_slverr);
    end
  end

  assign bus.aw_valid = aw_valid_q;
  assign bus.aw_addr  = addr_q;
  assign bus.w_valid  = w_valid_q;
  assign bus.w_data   = wdata_q;
  assign bus.ar_valid = ar_valid_q;
  assign bus.ar_addr  = addr_q;
  // ready for the response for the whole wait
  assign bus.b_ready  = (state_q == st_write);
  assign bus.r_ready  = (state_q == st_read);

  // one-cycle pulse to the owner only
  assign rsp_valid = (state_q == st_resp) ? owner_q : '0;

  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus.aw_valid && !bus.aw_ready |=> bus.aw_valid && $stable(bus.aw_addr));
  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus.w_valid && !bus.w_ready |=> bus.w_valid && $stable(bus.w_data));
  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable(bus.ar_addr));

endmodule

`default_nettype wire

//--- src/reg_bank.sv
`default_nettype none
`timescale 1ns/1ps

module reg_bank
  import arb_share_pkg::*;
(
  input logic           clk,
  input logic           rst_n,
  axil_if.subordinate   bus
);

  data_t regs [num_regs_c];
  logic  wr_ready_q;
  logic  ar_ready_q;
  logic  b_valid_q;
  logic  r_valid_q;
  resp_t b_resp_q;
  resp_t r_resp_q;
  data_t r_data_q;
  logic  wr_hs;
  logic  ar_hs;
  logic  wr_in_range;
  logic  rd_in_range;

  // both write channels are accepted together
  assign wr_hs       = bus.aw_valid && bus.w_valid && wr_ready_q;
  assign ar_hs       = bus.ar_valid && ar_ready_q;
  // in range means below 0x40
  assign wr_in_range = (bus.aw_addr[7:6] == 2'b00);
  assign rd_in_range = (bus.ar_addr[7:6] == 2'b00);

  // ------------------------------------------------------------------
  // handshakes and storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ready_q <= 1'b0;
      ar_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
      for (int i = 0; i < num_regs_c; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // ready a cycle after valid, a single-cycle pulse
      wr_ready_q <= bus.aw_valid && bus.w_valid && !wr_ready_q && !b_valid_q;
      ar_ready_q <= bus.ar_valid && !ar_ready_q && !r_valid_q;
      if (wr_hs) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_in_range ? resp_okay : resp_slverr;
        // out of range writes are dropped
        if (wr_in_range) regs[bus.aw_addr[5:2]] <= bus.w_data;
      end else if (bus.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (ar_hs) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_in_range ? resp_okay : resp_slverr;
        r_data_q  <= rd_in_range ? regs[bus.ar_addr[5:2]] : '0;
      end else if (bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  assign bus.aw_ready = wr_ready_q;
  assign bus.w_ready  = wr_ready_q;
  assign bus.b_valid  = b_valid_q;
  assign bus.b_resp   = b_resp_q;
  assign bus.ar_ready = ar_ready_q;
  assign bus.r_valid  = r_valid_q;
  assign bus.r_resp   = r_resp_q;
  assign bus.r_data   = r_data_q;

  // no new transaction completes over a pending response
  a_b_single: assert property (@(posedge clk) disable iff (!rst_n)
    bus.b_valid && !bus.b_ready |-> !wr_hs);
  a_r_single: assert property (@(posedge clk) disable iff (!rst_n)
    bus.r_valid && !bus.r_ready |-> !ar_hs);

endmodule

`default_nettype wire

//--- src/req_capture.sv
`default_nettype none
`timescale 1ns/1ps

module req_capture
  import arb_share_pkg::*;
#(
  parameter int num_requesters = num_req_c
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [num_requesters-1:0]  req_valid,
  output logic [num_requesters-1:0]  req_ready,
  input  logic [num_requesters-1:0]  req_write,
  input  addr_t [num_requesters-1:0] req_addr,
  input  data_t [num_requesters-1:0] req_wdata,
  input  logic [num_requesters-1:0]  grant_take,
  output logic [num_requesters-1:0]  pending,
  output logic [num_requesters-1:0]  cmd_write,
  output addr_t [num_requesters-1:0] cmd_addr,
  output data_t [num_requesters-1:0] cmd_wdata
);

  // one slot per requester, full until the issuer takes it
  logic [num_requesters-1:0] full_q;
  logic [num_requesters-1:0] full_next;
  logic [num_requesters-1:0] ready_q;
  logic [num_requesters-1:0] accept;

  assign accept    = req_valid & ready_q;
  // take empties a slot, a handshake fills it
  assign full_next = (full_q & ~grant_take) | accept;

  // ready is registered so it stays low through reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q  <= '0;
      ready_q <= '0;
    end else begin
      full_q  <= full_next;
      ready_q <= ~full_next;
    end
  end

  // command payload, loaded on the handshake only
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_requesters; i++) begin
      if (accept[i]) begin
        cmd_write[i] <= req_write[i];
        cmd_addr[i]  <= req_addr[i];
        cmd_wdata[i] <= req_wdata[i];
      end
    end
  end

  assign req_ready = ready_q;
  assign pending   = full_q;

  // the issuer may only take a slot that holds a command
  a_take_pending: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_take & ~full_q) == '0);

endmodule

`default_nettype wire

//--- src/rr_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module rr_arbiter #(
  // two or more
  parameter int num_requesters = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable_priority_update,
  input  logic [num_requesters-1:0] request,
  output logic [num_requesters-1:0] grant
);

  // ------------------------------------------------------------------
  // priority state
  // ------------------------------------------------------------------
  // last_grant is the lowest priority requester
  // the index just above it (mod num_requesters) is the highest
  logic [num_requesters-1:0] last_grant;
  logic [num_requesters-1:0] priority_mask;
  logic [num_requesters-1:0] request_high;
  logic [num_requesters-1:0] grant_high;
  logic [num_requesters-1:0] grant_wrap;

  // lowest set bit wins, a plain priority encoder
  function automatic logic [num_requesters-1:0] lowest_set(
    input logic [num_requesters-1:0] vec
  );
    logic [num_requesters-1:0] result;
    logic                      found;
    result = '0;
    found  = 1'b0;
    for (int i = 0; i < num_requesters; i++) begin
      if (vec[i] && !found) begin
        result[i] = 1'b1;
        found     = 1'b1;
      end
    end
    return result;
  endfunction

  // mask covers the last grant and everything below it
  for (genvar i = 0; i < num_requesters; i++) begin : gen_mask
    assign priority_mask[i] = |last_grant[num_requesters-1:i];
  end

  // requests above the last grant come first
  assign request_high = request & ~priority_mask;
  assign grant_high   = lowest_set(request_high);
  // nothing above, wrap around to the full vector
  assign grant_wrap   = lowest_set(request);
  assign grant        = (|request_high) ? grant_high : grant_wrap;

  // top bit set out of reset so index 0 leads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= {1'b1, {(num_requesters-1){1'b0}}};
    end else if (enable_priority_update && |request) begin
      last_grant <= grant;
    end
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~request) == '0));

endmodule

`default_nettype wire
